// ==== hdl/tester_pkg.sv ====
// Shared widths, command codes and payload types, imported by the tester RTL
package tester_pkg;

    parameter int ADDR_W = 26;  // Tester address width
    parameter int DATA_W = 64;  // Up to eight bytes per access

    // Byte count is 2**code
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } size_t;

    // Panel commands on the 3-bit selector
    typedef enum logic [2:0] {
        CMD_ADDR_LO  = 3'd0,  // sw -> addr[9:0]
        CMD_ADDR_MID = 3'd1,  // sw -> addr[19:10]
        CMD_ADDR_HI  = 3'd2,  // sw[5:0] -> addr[25:20]
        CMD_SIZE     = 3'd3,
        CMD_DATA     = 3'd4,  // Shift in one write byte
        CMD_WRITE    = 3'd5,
        CMD_READ     = 3'd6,
        CMD_SHOW     = 3'd7   // Next byte on the displays
    } cmd_t;

    // Request toward the access engine
    typedef struct packed {
        logic              write;
        size_t             size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;  // Byte i in bits 8i+7..8i
    } mem_req_t;

    // Read result, little-endian, unused upper bytes zero
    typedef logic [DATA_W-1:0] rd_data_t;

    // Index of the last byte of an access (0, 1, 3 or 7)
    function automatic logic [2:0] last_byte_idx(size_t size);
        logic [3:0] count;
        count = 4'd1 << size;
        return count[2:0] - 3'd1;
    endfunction

endpackage

// ==== hdl/hex_to_sseg.sv ====
// Hex digit to seven-segment glyph, active low, one instance per display
module hex_to_sseg (
    input  logic [3:0] hexa,
    output logic [6:0] sseg
);

    // Bit order gfedcba, 0 lights a segment
    always_comb begin
        case (hexa)
            4'h0:    sseg = 7'b1000000;
            4'h1:    sseg = 7'b1111001;
            4'h2:    sseg = 7'b0100100;
            4'h3:    sseg = 7'b0110000;
            4'h4:    sseg = 7'b0011001;
            4'h5:    sseg = 7'b0010010;
            4'h6:    sseg = 7'b0000010;
            4'h7:    sseg = 7'b1111000;
            4'h8:    sseg = 7'b0000000;
            4'h9:    sseg = 7'b0010000;
            4'hA:    sseg = 7'b0001000;
            4'hB:    sseg = 7'b0000011;  // Lower case b
            4'hC:    sseg = 7'b1000110;
            4'hD:    sseg = 7'b0100001;  // Lower case d
            4'hE:    sseg = 7'b0000110;
            default: sseg = 7'b0001110;  // F
        endcase
    end

endmodule

// ==== hdl/handshake_slot.sv ====
// One-entry req/ack buffer that sits between a producer and a consumer for any payload type
module handshake_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     in_req,
    output logic     in_ack,
    input  payload_t in_payload,
    output logic     out_req,
    input  logic     out_ack,
    output payload_t out_payload
);

    payload_t data_q;
    logic     full;
    logic     cap_q;    // Capture happened last cycle
    logic     capture;

    // New entry only when empty and the previous ack has dropped
    assign capture = in_req && !full && !in_ack;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 1'b0;
            cap_q   <= 1'b0;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            cap_q <= capture;

            // Input side
            if (cap_q)
                in_ack <= 1'b1;
            else if (in_ack && !in_req)
                in_ack <= 1'b0;

            // Output side
            if (capture) begin
                full    <= 1'b1;
                out_req <= !out_ack;  // Held back until the old ack is gone
            end else if (full && out_req && out_ack) begin
                full    <= 1'b0;
                out_req <= 1'b0;
            end else if (full && !out_req && !out_ack) begin
                out_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture)
            data_q <= in_payload;
    end

    assign out_payload = data_q;

endmodule

// ==== hdl/mem_access_engine.sv ====
// Byte-serial access engine on an on-chip byte memory, standing in for the SDRAM controller
module mem_access_engine #(
    parameter int MEM_AW = 8
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 mem_req,
    output logic                 mem_ack,
    input  tester_pkg::mem_req_t mem_payload,
    output logic                 rsp_req,
    input  logic                 rsp_ack,
    output tester_pkg::rd_data_t rsp_payload
);
    import tester_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,   // One byte per cycle
        ST_RSP    // Posting read data
    } state_t;

    state_t            state;
    logic [7:0]        mem [2**MEM_AW];
    mem_req_t          req_q;
    rd_data_t          rd_buf;
    logic [2:0]        cnt;
    logic [MEM_AW-1:0] byte_addr;
    logic              take;

    assign take = (state == ST_IDLE) && mem_req && !mem_ack;

    // Upper address bits dropped, so addresses alias
    assign byte_addr = req_q.addr[MEM_AW-1:0] + MEM_AW'(cnt);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            cnt     <= 3'd0;
            mem_ack <= 1'b0;
            rsp_req <= 1'b0;
        end else begin
            // Early ack lets the request slot refill while we work
            if (take)
                mem_ack <= 1'b1;
            else if (mem_ack && !mem_req)
                mem_ack <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (take) begin
                        cnt   <= 3'd0;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (cnt == last_byte_idx(req_q.size)) begin
                        cnt   <= 3'd0;
                        state <= req_q.write ? ST_IDLE : ST_RSP;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                ST_RSP: begin
                    if (!rsp_req && !rsp_ack) begin
                        rsp_req <= 1'b1;
                    end else if (rsp_req && rsp_ack) begin
                        rsp_req <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Datapath and byte array
    always_ff @(posedge clock) begin
        if (take) begin
            req_q  <= mem_payload;
            rd_buf <= '0;              // Bytes past the size stay zero
        end else if (state == ST_RUN) begin
            if (req_q.write)
                mem[byte_addr] <= req_q.data[8*cnt +: 8];
            else
                rd_buf[8*cnt +: 8] <= mem[byte_addr];
        end
    end

    assign rsp_payload = rd_buf;

endmodule

// ==== hdl/tester_panel.sv ====
// Operator panel: decodes key presses into requests and holds the read byte for the displays
module tester_panel (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 key,
    input  tester_pkg::cmd_t     cmd,
    input  logic [9:0]           sw,
    output logic                 req_req,
    input  logic                 req_ack,
    output tester_pkg::mem_req_t req_payload,
    input  logic                 rsp_req,
    output logic                 rsp_ack,
    input  tester_pkg::rd_data_t rsp_payload,
    output logic [3:0]           nib_lo,
    output logic [3:0]           nib_hi,
    output logic                 busy,
    output logic                 done
);
    import tester_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,   // Request handshake in progress
        ST_RSP    // Waiting for read data
    } state_t;

    state_t              state;
    logic                key_q;
    logic                act;       // One cycle after a rising key edge
    logic                op_write;
    logic [ADDR_W-1:0]   addr_q;
    size_t               size_q;
    logic [DATA_W-1:0]   wdata_q;
    rd_data_t            rdata_q;   // Last read result
    size_t               rd_size_q; // Size of that read
    logic [2:0]          show_idx;
    logic [7:0]          shown_byte;

    // Key edge detector, registered once more so cmd and sw are sampled a cycle later
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            key_q <= 1'b0;
            act   <= 1'b0;
        end else begin
            key_q <= key;
            act   <= key & ~key_q;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            op_write  <= 1'b0;
            addr_q    <= '0;
            size_q    <= SIZE_BYTE;
            wdata_q   <= '0;
            rdata_q   <= '0;
            rd_size_q <= SIZE_BYTE;
            show_idx  <= 3'd0;
            req_req   <= 1'b0;
            rsp_ack   <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rsp_ack && !rsp_req)
                rsp_ack <= 1'b0;  // Return to zero

            case (state)
                ST_IDLE: begin
                    if (act) begin
                        case (cmd)
                            CMD_ADDR_LO:  addr_q[9:0]   <= sw;
                            CMD_ADDR_MID: addr_q[19:10] <= sw;
                            CMD_ADDR_HI:  addr_q[25:20] <= sw[5:0];
                            CMD_SIZE:     size_q        <= size_t'(sw[1:0]);
                            CMD_DATA:     wdata_q       <= {wdata_q[DATA_W-9:0], sw[7:0]};
                            CMD_WRITE: begin
                                op_write <= 1'b1;
                                state    <= ST_REQ;
                            end
                            CMD_READ: begin
                                op_write <= 1'b0;
                                state    <= ST_REQ;
                            end
                            CMD_SHOW: begin
                                // Wraps after the last byte of the held read
                                if (show_idx == last_byte_idx(rd_size_q))
                                    show_idx <= 3'd0;
                                else
                                    show_idx <= show_idx + 3'd1;
                            end
                        endcase
                    end
                end
                ST_REQ: begin
                    // Raise req only once the previous ack has cleared
                    if (!req_req && !req_ack) begin
                        req_req <= 1'b1;
                    end else if (req_req && req_ack) begin
                        req_req <= 1'b0;
                        if (op_write) begin
                            state <= ST_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= ST_RSP;
                        end
                    end
                end
                ST_RSP: begin
                    if (rsp_req && !rsp_ack) begin
                        rdata_q   <= rsp_payload;
                        rd_size_q <= size_q;
                        show_idx  <= 3'd0;   // New read starts at byte 0
                        rsp_ack   <= 1'b1;
                        done      <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy = (state != ST_IDLE);

    // Stable while req is up, registers only change when idle
    assign req_payload = '{write: op_write, size: size_q, addr: addr_q, data: wdata_q};

    assign shown_byte = rdata_q[8*show_idx +: 8];
    assign nib_lo     = shown_byte[3:0];
    assign nib_hi     = shown_byte[7:4];

endmodule

// ==== hdl/sdram_tester.sv ====
// Top level of the memory tester: panel, two handshake slots, access engine and displays
module sdram_tester #(
    parameter int MEM_AW = 8
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             key,
    input  tester_pkg::cmd_t cmd,
    input  logic [9:0]       sw,
    output logic [6:0]       seg_lsb,
    output logic [6:0]       seg_msb,
    output logic             busy,
    output logic             done
);
    import tester_pkg::*;

    // Panel to request slot
    logic     req_req;
    logic     req_ack;
    mem_req_t req_payload;
    // Request slot to engine
    logic     mem_req;
    logic     mem_ack;
    mem_req_t mem_payload;
    // Engine to response slot
    logic     rsp_in_req;
    logic     rsp_in_ack;
    rd_data_t rsp_in_payload;
    // Response slot to panel
    logic     rsp_req;
    logic     rsp_ack;
    rd_data_t rsp_payload;

    logic [3:0] nib_lo;
    logic [3:0] nib_hi;

    tester_panel u_panel (
        .clock(clock), .arst_n(arst_n), .key(key), .cmd(cmd), .sw(sw),
        .req_req(req_req), .req_ack(req_ack), .req_payload(req_payload),
        .rsp_req(rsp_req), .rsp_ack(rsp_ack), .rsp_payload(rsp_payload),
        .nib_lo(nib_lo), .nib_hi(nib_hi), .busy(busy), .done(done)
    );

    handshake_slot #(.payload_t(mem_req_t)) u_req_slot (
        .clock(clock), .arst_n(arst_n),
        .in_req(req_req), .in_ack(req_ack), .in_payload(req_payload),
        .out_req(mem_req), .out_ack(mem_ack), .out_payload(mem_payload)
    );

    mem_access_engine #(.MEM_AW(MEM_AW)) u_engine (
        .clock(clock), .arst_n(arst_n),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_payload(mem_payload),
        .rsp_req(rsp_in_req), .rsp_ack(rsp_in_ack), .rsp_payload(rsp_in_payload)
    );

    handshake_slot #(.payload_t(rd_data_t)) u_rsp_slot (
        .clock(clock), .arst_n(arst_n),
        .in_req(rsp_in_req), .in_ack(rsp_in_ack), .in_payload(rsp_in_payload),
        .out_req(rsp_req), .out_ack(rsp_ack), .out_payload(rsp_payload)
    );

    hex_to_sseg u_seg_lsb (.hexa(nib_lo), .sseg(seg_lsb));
    hex_to_sseg u_seg_msb (.hexa(nib_hi), .sseg(seg_msb));

endmodule

// ==== dv/sdram_tester_tb.sv ====
// Self-checking testbench for the memory tester that runs a command table and checks flags and displays
module sdram_tester_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import tester_pkg::*;

    typedef enum logic [1:0] {
        CK_NONE,     // Flags only
        CK_SEG,      // Flags and both displays
        CK_START,    // Start a read and move on while busy
        CK_IGNORED   // Pressed while busy and then waits for that read
    } check_t;

    typedef struct packed {
        cmd_t       cmd;
        logic [9:0] sw;
        check_t     kind;
    } step_t;

    logic       clock;
    logic       arst_n;
    logic       key;
    cmd_t       cmd;
    logic [9:0] sw;
    logic [6:0] seg_lsb;
    logic [6:0] seg_msb;
    logic       busy;
    logic       done;

    step_t             steps[$];
    logic [31:0]       lcg_state;
    logic [7:0]        mem_model [256];
    logic [ADDR_W-1:0] m_addr;
    size_t             m_size;
    logic [DATA_W-1:0] m_wdata;
    rd_data_t          m_rdata;
    size_t             m_rsize;
    logic [2:0]        m_show;

    // Active low with bit 0 as segment a
    logic [6:0] font [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    sdram_tester #(.MEM_AW(8)) i_sdram_tester (
        .clock(clock), .arst_n(arst_n), .key(key), .cmd(cmd), .sw(sw),
        .seg_lsb(seg_lsb), .seg_msb(seg_msb), .busy(busy), .done(done)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int byte_count(size_t s);
        return 1 << s;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input logic got_busy, input logic got_done,
                              input logic exp_busy, input logic exp_done, input string what);
        if (got_busy !== exp_busy || got_done !== exp_done)
            stop_with_failure($sformatf("mismatch at %0t: %s busy=%b done=%b, expected %b %b",
                                        $time, what, got_busy, got_done, exp_busy, exp_done));
    endtask

    task automatic check_seg(input logic [6:0] got_lsb, input logic [6:0] got_msb,
                             input string what);
        logic [7:0] shown;
        shown = m_rdata[8*m_show +: 8];  // Byte under the show index
        if (got_lsb !== font[shown[3:0]] || got_msb !== font[shown[7:4]])
            stop_with_failure($sformatf("mismatch at %0t: %s seg=%h/%h, expected byte %h",
                                        $time, what, got_msb, got_lsb, shown));
    endtask

    task automatic apply_model(input cmd_t c, input logic [9:0] s);
        logic [7:0] a;
        case (c)
            CMD_ADDR_LO:  m_addr[9:0]   = s;
            CMD_ADDR_MID: m_addr[19:10] = s;
            CMD_ADDR_HI:  m_addr[25:20] = s[5:0];
            CMD_SIZE:     m_size        = size_t'(s[1:0]);
            CMD_DATA:     m_wdata       = {m_wdata[DATA_W-9:0], s[7:0]};
            CMD_WRITE: begin
                for (int i = 0; i < byte_count(m_size); i++) begin
                    a = m_addr[7:0] + 8'(i);  // Wraps modulo 256
                    mem_model[a] = m_wdata[8*i +: 8];
                end
            end
            CMD_READ: begin
                m_rdata = '0;
                for (int i = 0; i < byte_count(m_size); i++) begin
                    a = m_addr[7:0] + 8'(i);
                    m_rdata[8*i +: 8] = mem_model[a];
                end
                m_rsize = m_size;
                m_show  = 3'd0;
            end
            default: begin
                if (int'(m_show) == byte_count(m_rsize) - 1)
                    m_show = 3'd0;
                else
                    m_show = m_show + 3'd1;
            end
        endcase
    endtask

    task automatic add_step(input cmd_t c, input logic [9:0] s, input check_t k);
        steps.push_back('{cmd: c, sw: s, kind: k});
    endtask

    task automatic add_random_data(input int count);
        logic [31:0] r;
        repeat (count) begin
            r = next_rand();
            add_step(CMD_DATA, {2'b00, r[23:16]}, CK_NONE);
        end
    endtask

    task automatic add_shows(input int count);
        repeat (count) add_step(CMD_SHOW, 10'd0, CK_SEG);
    endtask

    task automatic build_table();
        logic [9:0]  base;
        logic [31:0] r;
        // One byte at an address above 255 that aliases onto its low bits
        add_step(CMD_ADDR_LO, 10'h3a5, CK_NONE);
        add_step(CMD_ADDR_MID, 10'h155, CK_NONE);
        add_step(CMD_ADDR_HI, 10'h02a, CK_NONE);
        add_step(CMD_SIZE, 10'd0, CK_NONE);
        add_step(CMD_DATA, 10'h05c, CK_NONE);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_step(CMD_ADDR_HI, 10'd0, CK_NONE);
        add_step(CMD_ADDR_MID, 10'd0, CK_NONE);
        add_step(CMD_ADDR_LO, 10'h0a5, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        // Eight bytes with the display walking 0..7 and wrapping
        add_step(CMD_ADDR_LO, 10'h010, CK_NONE);
        add_step(CMD_SIZE, 10'd3, CK_NONE);
        for (int i = 1; i <= 8; i++)
            add_step(CMD_DATA, 10'(8'h11 * i), CK_NONE);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(8);
        // Overlapping writes at a random base
        r    = next_rand();
        base = r[25:16];
        r    = next_rand();
        add_step(CMD_ADDR_MID, r[25:16], CK_NONE);
        add_step(CMD_ADDR_HI, {4'd0, r[31:26]}, CK_NONE);
        add_step(CMD_ADDR_LO, base, CK_NONE);
        add_step(CMD_SIZE, 10'd3, CK_NONE);
        add_random_data(8);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_ADDR_LO, base + 10'd1, CK_NONE);
        add_step(CMD_SIZE, 10'd1, CK_NONE);
        add_random_data(2);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_ADDR_LO, base + 10'd2, CK_NONE);
        add_step(CMD_SIZE, 10'd2, CK_NONE);
        add_random_data(4);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_ADDR_LO, base, CK_NONE);
        add_step(CMD_SIZE, 10'd3, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(7);
        add_step(CMD_ADDR_LO, base + 10'd3, CK_NONE);
        add_step(CMD_SIZE, 10'd2, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(4);
        add_step(CMD_ADDR_LO, base + 10'd1, CK_NONE);
        add_step(CMD_SIZE, 10'd1, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(2);
        // Read right behind a long write checks ordering through the slots
        add_step(CMD_ADDR_LO, 10'h0c8, CK_NONE);
        add_step(CMD_SIZE, 10'd3, CK_NONE);
        add_random_data(8);
        add_step(CMD_WRITE, 10'd0, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(7);
        // Address change while a read runs must be dropped
        add_step(CMD_ADDR_LO, 10'h010, CK_NONE);
        add_step(CMD_SIZE, 10'd0, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_START);
        add_step(CMD_ADDR_LO, 10'h0c8, CK_IGNORED);
        add_step(CMD_SIZE, 10'd3, CK_NONE);
        add_step(CMD_READ, 10'd0, CK_SEG);
        add_shows(7);
    endtask

    // One key press that returns 1 ns after the edge where the panel acts
    task automatic press_key(input step_t st);
        cmd = st.cmd;
        sw  = st.sw;
        key = 1'b1;
        @(posedge clock);
        #1 key = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            if (n == 64)
                stop_with_failure({"timeout: done did not rise within 64 cycles for ", what});
            else begin
                @(posedge clock);
                #1;
                n++;
            end
        end
    endtask

    task automatic run_step(input step_t st, input int idx);
        string what;
        what = $sformatf("step %0d %s", idx, st.cmd.name());
        press_key(st);
        case (st.kind)
            CK_START: begin
                apply_model(st.cmd, st.sw);
                check_flag(busy, done, 1'b1, 1'b0, what);
            end
            CK_IGNORED: begin
                check_flag(busy, done, 1'b1, 1'b0, what);
                wait_done(what);
                check_flag(busy, done, 1'b0, 1'b1, what);
                check_seg(seg_lsb, seg_msb, what);
            end
            default: begin
                apply_model(st.cmd, st.sw);
                if (st.cmd == CMD_WRITE || st.cmd == CMD_READ) begin
                    wait_done(what);
                    check_flag(busy, done, 1'b0, 1'b1, what);
                end else begin
                    check_flag(busy, done, 1'b0, 1'b0, what);
                end
                if (st.kind == CK_SEG)
                    check_seg(seg_lsb, seg_msb, what);
            end
        endcase
    endtask

    initial begin
        clock     = 1'b0;
        arst_n    = 1'b0;
        key       = 1'b0;
        cmd       = CMD_ADDR_LO;
        sw        = '0;
        lcg_state = 32'h5f70_54dc;
        m_addr    = '0;
        m_size    = SIZE_BYTE;
        m_wdata   = '0;
        m_rdata   = '0;
        m_rsize   = SIZE_BYTE;
        m_show    = 3'd0;
        build_table();

        repeat (3) @(posedge clock);
        #1 arst_n = 1'b1;
        @(posedge clock);
        #1;
        check_flag(busy, done, 1'b0, 1'b0, "after reset");
        check_seg(seg_lsb, seg_msb, "after reset");  // Glyph 0 on both

        foreach (steps[i])
            run_step(steps[i], i);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/tester_pkg.sv
hdl/hex_to_sseg.sv
hdl/handshake_slot.sv
hdl/mem_access_engine.sv
hdl/tester_panel.sv
hdl/sdram_tester.sv
dv/sdram_tester_tb.sv

// ==== Bender.yml ====
package:
  name: sdram_tester

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hdl/tester_pkg.sv
      - hdl/hex_to_sseg.sv
      - hdl/handshake_slot.sv
      - hdl/mem_access_engine.sv
      - hdl/tester_panel.sv
      - hdl/sdram_tester.sv

  # Testbench, top module sdram_tester_tb
  - target: test
    files:
      - dv/sdram_tester_tb.sv
